// File: ex_defs.svh
// ====================================================================
// widths, link offset and major opcodes of the rv32i execute stage
// ====================================================================
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`default_nettype none

// data path
`define EX_XLEN      32       // data and address width
`define EX_SHAMT_W   5        // shift amount bits used by the shifter
`define EX_LINK_OFS  4        // pc increment written by jal / jalr

// ====================================================================
// major opcodes, instr[6:0]
// ====================================================================
`define EX_OPC_LUI     7'b0110111
`define EX_OPC_AUIPC   7'b0010111
`define EX_OPC_JAL     7'b1101111
`define EX_OPC_JALR    7'b1100111
`define EX_OPC_BRANCH  7'b1100011
`define EX_OPC_LOAD    7'b0000011
`define EX_OPC_STORE   7'b0100011
`define EX_OPC_OPIMM   7'b0010011   // alu with immediate, incl. shift imm
`define EX_OPC_OP      7'b0110011   // register-register alu

`default_nettype wire

`endif

// File: ex_pkg.sv
// ====================================================================
// instruction format views and operation enums of the execute stage
// ====================================================================
`default_nettype none

package ex_pkg;

    // one struct per rv32i format, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // the same instruction word seen through each format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU,
        OP_NONE
    } alu_op_e;

    // source of alu_q
    typedef enum logic [2:0] {
        RES_ALU, RES_IMM, RES_PCSUM, RES_LINK, RES_ZERO
    } res_sel_e;

endpackage

`default_nettype wire

// File: ex_decode.sv
// ====================================================================
// ex_decode: opcode / funct decode, immediate build, operand selects
// ====================================================================
`timescale 1ns/1ps
`include "ex_defs.svh"
`default_nettype none

module ex_decode
    import ex_pkg::*;
(
    input  wire instr_u              instr,
    output alu_op_e                  alu_op,
    output res_sel_e                 res_sel,
    output logic [`EX_XLEN-1:0]      imm,
    output logic                     use_imm,    // operand b is imm, not rs2
    output logic                     pc_rel,     // pc adder takes imm, else link offset
    output logic                     is_branch,
    output logic                     jump_kind   // jalr
);

    logic [`EX_XLEN-1:0] imm_i;
    logic [`EX_XLEN-1:0] imm_s;
    logic [`EX_XLEN-1:0] imm_b;
    logic [`EX_XLEN-1:0] imm_u;
    logic [`EX_XLEN-1:0] imm_j;

    // funct3 to alu op; alt is instr[30], sub_ok only for register ops
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt,
                                            input logic sub_ok);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && sub_ok) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;   // same ops for shift imm
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // ================================================================
    // immediates, sign-extended from the matching view
    // ================================================================
    assign imm_i = {{(`EX_XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{(`EX_XLEN-12){instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{(`EX_XLEN-12){instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
                    instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'b0};
    assign imm_j = {{(`EX_XLEN-20){instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
                    instr.j.imm_10_1, 1'b0};

    // ================================================================
    // opcode decode
    // ================================================================
    always_comb begin
        alu_op    = OP_NONE;
        res_sel   = RES_ZERO;
        imm       = '0;
        use_imm   = 1'b0;
        pc_rel    = 1'b0;
        is_branch = 1'b0;
        jump_kind = 1'b0;
        case (instr.r.opcode)
            `EX_OPC_LUI: begin
                res_sel = RES_IMM;
                imm     = imm_u;
            end
            `EX_OPC_AUIPC: begin
                res_sel = RES_PCSUM;
                imm     = imm_u;
                pc_rel  = 1'b1;          // pc + imm
            end
            `EX_OPC_JAL: begin
                res_sel = RES_LINK;      // target resolved earlier, only link here
                imm     = imm_j;
            end
            `EX_OPC_JALR: begin
                res_sel   = RES_LINK;
                imm       = imm_i;
                alu_op    = ALU_ADD;     // rs1 + imm is the target
                use_imm   = 1'b1;
                jump_kind = 1'b1;
            end
            `EX_OPC_BRANCH: begin
                imm       = imm_b;
                pc_rel    = 1'b1;        // target pc + imm
                is_branch = 1'b1;
                case (instr.b.funct3)
                    3'b000:  alu_op = BR_EQ;
                    3'b001:  alu_op = BR_NE;
                    3'b100:  alu_op = BR_LT;
                    3'b101:  alu_op = BR_GE;
                    3'b110:  alu_op = BR_LTU;
                    3'b111:  alu_op = BR_GEU;
                    default: alu_op = OP_NONE;   // never taken
                endcase
            end
            `EX_OPC_LOAD: begin
                res_sel = RES_ALU;       // address from rs1 adder
                alu_op  = ALU_ADD;
                imm     = imm_i;
                use_imm = 1'b1;
            end
            `EX_OPC_STORE: begin
                res_sel = RES_ALU;
                alu_op  = ALU_ADD;
                imm     = imm_s;
                use_imm = 1'b1;
            end
            `EX_OPC_OPIMM: begin
                res_sel = RES_ALU;
                imm     = imm_i;
                use_imm = 1'b1;
                alu_op  = alu_from_f3(instr.i.funct3, instr.r.funct7[5], 1'b0);
            end
            `EX_OPC_OP: begin
                res_sel = RES_ALU;
                alu_op  = alu_from_f3(instr.r.funct3, instr.r.funct7[5], 1'b1);
            end
            default: begin
                // unknown opcode, defaults give zero and no jump
                res_sel = RES_ZERO;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: ex_execute.sv
// ====================================================================
// ex_execute: two shared adders, comparators, shifter, logic unit
// and the branch condition
// ====================================================================
`timescale 1ns/1ps
`include "ex_defs.svh"
`default_nettype none

module ex_execute
    import ex_pkg::*;
(
    input  wire  [`EX_XLEN-1:0] rs1_val,
    input  wire  [`EX_XLEN-1:0] rs2_val,
    input  wire  [`EX_XLEN-1:0] pc,
    input  wire  alu_op_e       alu_op,
    input  wire  [`EX_XLEN-1:0] imm,
    input  wire                 use_imm,
    input  wire                 pc_rel,
    input  wire                 jump_kind,
    output logic [`EX_XLEN-1:0] alu_res,
    output logic [`EX_XLEN-1:0] pc_sum,     // pc + imm or pc + 4
    output logic [`EX_XLEN-1:0] base_sum,   // rs1 + operand b
    output logic                take        // branch true or jalr
);

    localparam logic [`EX_XLEN-1:0] link_ofs = `EX_LINK_OFS;

    logic [`EX_XLEN-1:0]    opb;        // imm or rs2
    logic [`EX_XLEN-1:0]    add_b;      // second input of rs1 adder
    logic [`EX_XLEN-1:0]    pc_b;       // second input of pc adder
    logic [`EX_SHAMT_W-1:0] shamt;
    logic [`EX_XLEN-1:0]    sll_res;
    logic [`EX_XLEN-1:0]    srl_res;
    logic [`EX_XLEN-1:0]    sra_mask;
    logic [`EX_XLEN-1:0]    sra_res;
    logic                   lt_s;
    logic                   lt_u;
    logic                   eq;
    logic                   br_cond;

    // ================================================================
    // shared adders
    // ================================================================
    assign opb   = use_imm ? imm : rs2_val;
    assign add_b = (alu_op == ALU_SUB) ? (~rs2_val + 1'b1) : opb;   // sub as add of -rs2

    // rs1 adder: add/sub, load/store address, jalr target
    assign base_sum = rs1_val + add_b;

    // pc adder: auipc and branch target, or link value
    assign pc_b   = pc_rel ? imm : link_ofs;
    assign pc_sum = pc + pc_b;

    // ================================================================
    // comparators, shared by slt/sltu and branches
    // ================================================================
    assign lt_s = $signed(rs1_val) < $signed(opb);
    assign lt_u = rs1_val < opb;
    assign eq   = rs1_val == opb;

    // ================================================================
    // shifter
    // ================================================================
    assign shamt   = opb[`EX_SHAMT_W-1:0];             // low bits only
    assign sll_res = rs1_val << shamt;
    assign srl_res = rs1_val >> shamt;

    // ones where logical shift kept data, sign fills the rest
    assign sra_mask = {`EX_XLEN{1'b1}} >> shamt;
    assign sra_res  = (srl_res & sra_mask) | ({`EX_XLEN{rs1_val[`EX_XLEN-1]}} & ~sra_mask);

    // ================================================================
    // result and branch condition
    // ================================================================
    always_comb begin
        case (alu_op)
            ALU_ADD,
            ALU_SUB:  alu_res = base_sum;
            ALU_SLT:  alu_res = {{(`EX_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: alu_res = {{(`EX_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  alu_res = rs1_val ^ opb;
            ALU_OR:   alu_res = rs1_val | opb;
            ALU_AND:  alu_res = rs1_val & opb;
            ALU_SLL:  alu_res = sll_res;
            ALU_SRL:  alu_res = srl_res;
            ALU_SRA:  alu_res = sra_res;
            default:  alu_res = '0;        // branches and none
        endcase
    end

    always_comb begin
        case (alu_op)
            BR_EQ:   br_cond = eq;
            BR_NE:   br_cond = !eq;
            BR_LT:   br_cond = lt_s;
            BR_GE:   br_cond = !lt_s;
            BR_LTU:  br_cond = lt_u;
            BR_GEU:  br_cond = !lt_u;
            default: br_cond = 1'b0;
        endcase
    end

    assign take = br_cond | jump_kind;     // jalr always jumps

endmodule

`default_nettype wire

// File: ex_result.sv
// ====================================================================
// ex_result: result select, jump address and output registers
// ====================================================================
`timescale 1ns/1ps
`include "ex_defs.svh"
`default_nettype none

module ex_result
    import ex_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 in_valid,
    input  wire  res_sel_e      res_sel,
    input  wire                 take,
    input  wire                 is_branch,
    input  wire                 jump_kind,
    input  wire  [`EX_XLEN-1:0] alu_res,
    input  wire  [`EX_XLEN-1:0] pc_sum,
    input  wire  [`EX_XLEN-1:0] base_sum,
    input  wire  [`EX_XLEN-1:0] imm,
    output logic                res_valid,
    output logic [`EX_XLEN-1:0] alu_q,
    output logic                jump_en,
    output logic [`EX_XLEN-1:0] jump_addr
);

    logic [`EX_XLEN-1:0] q_d;
    logic                jump_d;
    logic [`EX_XLEN-1:0] addr_d;

    always_comb begin
        case (res_sel)
            RES_ALU:   q_d = alu_res;      // loads/stores land here via base_sum
            RES_IMM:   q_d = imm;          // lui
            RES_PCSUM: q_d = pc_sum;       // auipc, pc + imm
            RES_LINK:  q_d = pc_sum;       // jal / jalr, pc + 4
            default:   q_d = '0;
        endcase
    end

    assign jump_d = take & (is_branch | jump_kind);
    assign addr_d = !jump_d  ? '0 :
                    jump_kind ? {base_sum[`EX_XLEN-1:1], 1'b0} :   // jalr clears bit 0
                    pc_sum;

    // outputs are zero in any cycle that follows an idle input
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            alu_q     <= '0;
            jump_en   <= 1'b0;
            jump_addr <= '0;
        end else begin
            res_valid <= in_valid;
            alu_q     <= in_valid ? q_d : '0;
            jump_en   <= in_valid & jump_d;
            jump_addr <= in_valid ? addr_d : '0;
        end
    end

endmodule

`default_nettype wire

// File: ex_stage.sv
// ====================================================================
// ex_stage: registered rv32i execute stage, decode + execute + result
// ====================================================================
`timescale 1ns/1ps
`include "ex_defs.svh"
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 in_valid,    // one-cycle strobe
    input  wire  instr_u        instr,
    input  wire  [`EX_XLEN-1:0] rs1_val,
    input  wire  [`EX_XLEN-1:0] rs2_val,
    input  wire  [`EX_XLEN-1:0] pc,
    output logic                res_valid,
    output logic [`EX_XLEN-1:0] alu_q,
    output logic                jump_en,     // also flushes earlier stages
    output logic [`EX_XLEN-1:0] jump_addr
);

    // decode outputs
    alu_op_e             alu_op;
    res_sel_e            res_sel;
    logic [`EX_XLEN-1:0] imm;
    logic                use_imm;
    logic                pc_rel;
    logic                is_branch;
    logic                jump_kind;

    // execute outputs
    logic [`EX_XLEN-1:0] alu_res;
    logic [`EX_XLEN-1:0] pc_sum;
    logic [`EX_XLEN-1:0] base_sum;
    logic                take;

    ex_decode u_decode (
        .instr     (instr),
        .alu_op    (alu_op),
        .res_sel   (res_sel),
        .imm       (imm),
        .use_imm   (use_imm),
        .pc_rel    (pc_rel),
        .is_branch (is_branch),
        .jump_kind (jump_kind)
    );

    ex_execute u_execute (
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .pc        (pc),
        .alu_op    (alu_op),
        .imm       (imm),
        .use_imm   (use_imm),
        .pc_rel    (pc_rel),
        .jump_kind (jump_kind),
        .alu_res   (alu_res),
        .pc_sum    (pc_sum),
        .base_sum  (base_sum),
        .take      (take)
    );

    // single register stage, 1 cycle latency
    ex_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .res_sel   (res_sel),
        .take      (take),
        .is_branch (is_branch),
        .jump_kind (jump_kind),
        .alu_res   (alu_res),
        .pc_sum    (pc_sum),
        .base_sum  (base_sum),
        .imm       (imm),
        .res_valid (res_valid),
        .alu_q     (alu_q),
        .jump_en   (jump_en),
        .jump_addr (jump_addr)
    );

endmodule

`default_nettype wire

// File: tb_clock.sv
// ======================================================================
// testbench clock and reset generator
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;                  // release on an edge
    end

endmodule

`default_nettype wire

// File: tb_ex_stage.sv
// ======================================================================
// testbench for the execute stage with lfsr stimulus, reference model,
// one-cycle checks, timeout and report
// ======================================================================
`timescale 1ns/1ps
`include "ex_defs.svh"
`default_nettype none

module tb_ex_stage;

    localparam int n_idle   = 20;
    localparam int n_alu    = 300;
    localparam int n_upper  = 150;
    localparam int n_branch = 300;
    localparam int n_mem    = 150;
    localparam int n_stream = 400;
    localparam int timeout_cycles = 10 + n_idle + n_alu + n_upper + n_branch + n_mem
                                    + n_stream + 100;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] instr;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] pc;
    logic        res_valid;
    logic [31:0] alu_q;
    logic        jump_en;
    logic [31:0] jump_addr;

    logic [31:0] lfsr;
    logic [65:0] exp_q[$];          // {res_valid, jump_en, alu_q, jump_addr}
    int          cycle_cnt;
    int          errors;
    int          checks;
    int          tests_run;
    int          err_mark;
    int          chk_mark;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    ex_stage i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .pc        (pc),
        .res_valid (res_valid),
        .alu_q     (alu_q),
        .jump_en   (jump_en),
        .jump_addr (jump_addr)
    );

    // ==================================================================
    // random numbers
    // ==================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // taps 32,22,2,1
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // ==================================================================
    // reference model from the rv32i encoding
    // ==================================================================
    function automatic logic [65:0] model_out(input logic v, input logic [31:0] ins,
                                              input logic [31:0] r1, input logic [31:0] r2,
                                              input logic [31:0] p);
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] b;
        logic [31:0] q;
        logic [31:0] ja;
        logic        je;
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'h000};
        b     = (ins[6:0] == `EX_OPC_OP) ? r2 : imm_i;
        q     = '0;
        ja    = '0;
        je    = 1'b0;
        case (ins[6:0])
            `EX_OPC_LUI:   q = imm_u;
            `EX_OPC_AUIPC: q = p + imm_u;
            `EX_OPC_JAL:   q = p + 32'd4;
            `EX_OPC_JALR: begin
                q  = p + 32'd4;
                je = 1'b1;
                ja = (r1 + imm_i) & 32'hffff_fffe;
            end
            `EX_OPC_BRANCH: begin
                case (ins[14:12])
                    3'b000:  je = (r1 == r2);
                    3'b001:  je = (r1 != r2);
                    3'b100:  je = ($signed(r1) < $signed(r2));
                    3'b101:  je = ($signed(r1) >= $signed(r2));
                    3'b110:  je = (r1 < r2);
                    3'b111:  je = (r1 >= r2);
                    default: je = 1'b0;
                endcase
                ja = je ? (p + imm_b) : 32'h0;
            end
            `EX_OPC_LOAD:  q = r1 + imm_i;
            `EX_OPC_STORE: q = r1 + imm_s;
            `EX_OPC_OPIMM,
            `EX_OPC_OP: begin
                case (ins[14:12])
                    3'b000:  q = (ins[6:0] == `EX_OPC_OP && ins[30]) ? (r1 - r2) : (r1 + b);
                    3'b001:  q = r1 << b[4:0];
                    3'b010:  q = {31'b0, $signed(r1) < $signed(b)};
                    3'b011:  q = {31'b0, r1 < b};
                    3'b100:  q = r1 ^ b;
                    3'b101: begin
                        if (ins[30])
                            q = $signed(r1) >>> b[4:0];
                        else
                            q = r1 >> b[4:0];
                    end
                    3'b110:  q = r1 | b;
                    default: q = r1 & b;
                endcase
            end
            default: q = '0;
        endcase
        return v ? {1'b1, je, q, ja} : 66'h0;
    endfunction

    // ==================================================================
    // stimulus and checks
    // ==================================================================
    task automatic compare_outputs(input logic [65:0] e);
        checks++;
        if (res_valid !== e[65]) begin
            $display("Fail res_valid at cycle %0d: expected %h, got %h", cycle_cnt, e[65],
                     res_valid);
            errors++;
        end
        if (jump_en !== e[64]) begin
            $display("Fail jump_en at cycle %0d: expected %h, got %h", cycle_cnt, e[64], jump_en);
            errors++;
        end
        if (alu_q !== e[63:32]) begin
            $display("Fail alu_q at cycle %0d: expected %h, got %h", cycle_cnt, e[63:32], alu_q);
            errors++;
        end
        if (jump_addr !== e[31:0]) begin
            $display("Fail jump_addr at cycle %0d: expected %h, got %h", cycle_cnt, e[31:0],
                     jump_addr);
            errors++;
        end
    endtask

    // drive one item, check the one before it
    task automatic run_cycle(input logic v, input logic [31:0] ins, input logic [31:0] r1,
                             input logic [31:0] r2, input logic [31:0] p);
        @(posedge clk);
        in_valid <= v;
        instr    <= ins;
        rs1_val  <= r1;
        rs2_val  <= r2;
        pc       <= p;
        exp_q.push_back(model_out(v, ins, r1, r2, p));
        @(negedge clk);
        if (exp_q.size() > 1)
            compare_outputs(exp_q.pop_front());
    endtask

    // class 0 op, 1 op-imm, 2 lui, 3 auipc, 4 jal, 5 jalr, 6 branch, 7 load, 8 store
    task automatic make_instr(input int cls, output logic [31:0] ins);
        logic [31:0] rnd;
        logic [31:0] sel;
        logic [2:0]  f3;
        logic [6:0]  f7;
        get_bits(32, rnd);
        get_bits(4, sel);
        f3 = sel[2:0];
        f7 = (sel[3] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        case (cls)
            0: ins = {f7, rnd[24:15], f3, rnd[11:7], `EX_OPC_OP};
            1: begin
                if (f3 == 3'b001 || f3 == 3'b101)
                    ins = {(f3 == 3'b101) ? f7 : 7'h00, rnd[24:15], f3, rnd[11:7],
                           `EX_OPC_OPIMM};                       // shift imm
                else
                    ins = {rnd[31:15], f3, rnd[11:7], `EX_OPC_OPIMM};
            end
            2: ins = {rnd[31:7], `EX_OPC_LUI};
            3: ins = {rnd[31:7], `EX_OPC_AUIPC};
            4: ins = {rnd[31:7], `EX_OPC_JAL};
            5: ins = {rnd[31:15], 3'b000, rnd[11:7], `EX_OPC_JALR};
            6: begin
                case (sel[3:0] % 6)
                    0:       f3 = 3'b000;
                    1:       f3 = 3'b001;
                    2:       f3 = 3'b100;
                    3:       f3 = 3'b101;
                    4:       f3 = 3'b110;
                    default: f3 = 3'b111;
                endcase
                ins = {rnd[31:15], f3, rnd[11:7], `EX_OPC_BRANCH};
            end
            7: ins = {rnd[31:15], 1'b0, sel[1:0] & 2'b10 | {1'b0, sel[0]}, rnd[11:7], `EX_OPC_LOAD};
            default: ins = {rnd[31:15], 1'b0, sel[1:0] & 2'b10 | {1'b0, sel[0]}, rnd[11:7],
                            `EX_OPC_STORE};
        endcase
    endtask

    // operands lean on sign boundaries and small shift-like values
    task automatic pick_operand(output logic [31:0] v);
        logic [31:0] mode;
        logic [31:0] rnd;
        get_bits(2, mode);
        get_bits(32, rnd);
        case (mode[1:0])
            2'd0: begin
                case (rnd[1:0])
                    2'd0:    v = 32'h8000_0000;
                    2'd1:    v = 32'h7fff_ffff;
                    2'd2:    v = 32'hffff_ffff;
                    default: v = 32'h0000_0000;
                endcase
            end
            2'd1:    v = {27'b0, rnd[4:0]};
            default: v = rnd;
        endcase
    endtask

    // vmode 0 mostly valid, 1 valid, 2 idle
    task automatic run_random(input int cls, input int vmode);
        logic [31:0] ins;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] rnd;
        logic [31:0] p;
        logic        v;
        make_instr(cls, ins);
        pick_operand(r1);
        pick_operand(r2);
        get_bits(2, rnd);
        if (cls == 6 && rnd[1:0] == 2'd0)
            r2 = r1;                                    // equal operands
        get_bits(32, rnd);
        p = {rnd[31:2], 2'b00};
        get_bits(3, rnd);
        v = (vmode == 1) || (vmode == 0 && rnd[2:0] != 3'd0);
        run_cycle(v, ins, r1, r2, p);
    endtask

    task automatic finish_test(input string name);
        run_cycle(1'b0, 32'h0, 32'h0, 32'h0, 32'h0);   // flush the last item
        tests_run++;
        $display("test %s done: %0d checks, %0d errors", name, checks - chk_mark,
                 errors - err_mark);
        chk_mark = checks;
        err_mark = errors;
    endtask

    // ==================================================================
    // test sequence
    // ==================================================================
    initial begin
        logic [31:0] rnd;
        in_valid  = 1'b1;                               // a jalr waits through reset
        instr     = {12'h7f0, 5'd3, 3'b000, 5'd1, `EX_OPC_JALR};
        rs1_val   = 32'h0001_2345;
        rs2_val   = 32'h0000_00ff;
        pc        = 32'h0000_0400;
        lfsr      = 32'h3afc;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        err_mark  = 0;
        chk_mark  = 0;

        // outputs stay zero during and right after reset
        @(posedge clk);
        @(negedge clk);
        while (rst_n !== 1'b1) begin
            compare_outputs(66'h0);
            @(negedge clk);
        end
        compare_outputs(66'h0);
        exp_q.push_back(model_out(in_valid, instr, rs1_val, rs2_val, pc));   // first edge out of reset
        for (int i = 0; i < n_idle; i++) begin
            get_bits(4, rnd);
            run_random(rnd[3:0] % 9, (i % 2 == 0) ? 1 : 2);
        end
        finish_test("reset");

        for (int i = 0; i < n_alu; i++) begin
            get_bits(1, rnd);
            run_random(rnd[0] ? 1 : 0, 0);
        end
        finish_test("alu");

        for (int i = 0; i < n_upper; i++) begin
            get_bits(2, rnd);
            run_random(2 + rnd[1:0], 0);
        end
        finish_test("upper");

        for (int i = 0; i < n_branch; i++)
            run_random(6, 0);
        finish_test("branch");

        for (int i = 0; i < n_mem; i++) begin
            get_bits(1, rnd);
            run_random(rnd[0] ? 8 : 7, 0);
        end
        finish_test("mem");

        for (int i = 0; i < n_stream; i++) begin
            get_bits(4, rnd);
            run_random(rnd[3:0] % 9, 1);                // back to back, mixed
        end
        finish_test("stream");

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // run length guard
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
ex_pkg.sv
ex_decode.sv
ex_execute.sv
ex_result.sv
ex_stage.sv
tb_clock.sv
tb_ex_stage.sv

// File: Makefile
TOOL    = verilator
FLAGS   = --binary --timing -Wno-fatal
TOP     = tb_ex_stage
FLIST   = all.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
